// File: rtl/gat_config.svh
// Matrix sizes, element widths and the Wishbone address map of the weight
// front end. Include wherever a size or a register offset is needed.
`ifndef GAT_CONFIG_SVH
`define GAT_CONFIG_SVH

// Element width of W, a and h
`define GAT_DATA_WIDTH 8

// W is FEAT_IN rows by FEAT_OUT columns
`define GAT_FEAT_IN 8
`define GAT_FEAT_OUT 4

// Attention vector a holds two halves of FEAT_OUT
`define GAT_A_DEPTH (2 * `GAT_FEAT_OUT)

// Staged words, W row-major followed by a
`define GAT_STAGE_DEPTH (`GAT_FEAT_IN * `GAT_FEAT_OUT + `GAT_A_DEPTH)

// Signed accumulator, wide enough for FEAT_IN products of 16 bits
`define GAT_WH_WIDTH 20

// Word address, top two bits select the region
`define GAT_WB_ADR_W 10

// Control region offsets
`define GAT_REG_CTRL 0
`define GAT_REG_STATUS 1

// Result region, WH from word 0 and a from this offset
`define GAT_A_BASE 16

`endif

// File: rtl/gat_pkg.sv
// Shared types of the weight front end. Modules refer to them by scoped
// names, the sizes come from the config header.
`include "gat_config.svh"

package gat_pkg;

  // One signed element of W, a or h
  typedef logic signed [`GAT_DATA_WIDTH-1:0] weight_t;

  // One signed WH accumulator
  typedef logic signed [`GAT_WH_WIDTH-1:0] wh_acc_t;

  // Address regions, taken from the top two bits of the word address
  typedef enum logic [1:0] {
    WB_STAGE   = 2'd0,
    WB_FEATURE = 2'd1,
    WB_RESULT  = 2'd2,
    WB_CTRL    = 2'd3
  } wb_region_e;

endpackage

// File: rtl/gat_bram.sv
// Simple dual-port memory, one synchronous write port and one read port
// with registered data. Used for staging and for the weight column banks.
`timescale 1ns/10ps

module gat_bram #(
  parameter int DATA_WIDTH = 8,
  parameter int DEPTH      = 16
) (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     we,
  input  logic [$clog2(DEPTH)-1:0] waddr,
  input  logic [DATA_WIDTH-1:0]    wdata,
  input  logic [$clog2(DEPTH)-1:0] raddr,
  output logic [DATA_WIDTH-1:0]    rdata
);

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // A read of the address being written returns the old word
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rdata <= '0;
    end else begin
      rdata <= mem[raddr];
    end
  end

endmodule

// File: rtl/gat_wb_port.sv
// Wishbone classic slave of the weight front end. Decodes the address map
// into staging writes, h writes, start pulses and readback of results.
`timescale 1ns/10ps
`include "gat_config.svh"

module gat_wb_port (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      wb_cyc,
  input  logic                                      wb_stb,
  input  logic                                      wb_we,
  input  logic [`GAT_WB_ADR_W-1:0]                  wb_adr,
  input  logic [31:0]                               wb_dat_w,
  output logic [31:0]                               wb_dat_r,
  output logic                                      wb_ack,
  output logic                                      stage_we,
  output logic [$clog2(`GAT_STAGE_DEPTH)-1:0]       stage_waddr,
  output gat_pkg::weight_t                          stage_wdata,
  output logic                                      load_start,
  output logic                                      wh_start,
  output logic [`GAT_FEAT_IN*`GAT_DATA_WIDTH-1:0]   h_flat,
  input  logic                                      w_ready,
  input  logic                                      a_ready,
  input  logic                                      wh_done,
  input  logic [`GAT_FEAT_OUT*`GAT_WH_WIDTH-1:0]    wh_flat,
  input  logic [`GAT_A_DEPTH*`GAT_DATA_WIDTH-1:0]   a_flat
);

  localparam int DW       = `GAT_DATA_WIDTH;
  localparam int WW       = `GAT_WH_WIDTH;
  localparam int OFF_W    = `GAT_WB_ADR_W - 2;
  localparam int STAGE_AW = $clog2(`GAT_STAGE_DEPTH);
  localparam int ROW_W    = $clog2(`GAT_FEAT_IN);
  localparam int COL_W    = $clog2(`GAT_FEAT_OUT);
  localparam int A_IW     = $clog2(`GAT_A_DEPTH);

  localparam logic [OFF_W-1:0] STAGE_END = OFF_W'(`GAT_STAGE_DEPTH);
  localparam logic [OFF_W-1:0] FEAT_END  = OFF_W'(`GAT_FEAT_IN);
  localparam logic [OFF_W-1:0] WH_END    = OFF_W'(`GAT_FEAT_OUT);
  localparam logic [OFF_W-1:0] A_LO      = OFF_W'(`GAT_A_BASE);
  localparam logic [OFF_W-1:0] A_HI      = OFF_W'(`GAT_A_BASE + `GAT_A_DEPTH);
  localparam logic [OFF_W-1:0] REG_CTRL  = OFF_W'(`GAT_REG_CTRL);
  localparam logic [OFF_W-1:0] REG_STAT  = OFF_W'(`GAT_REG_STATUS);

  gat_pkg::wb_region_e region;
  logic [OFF_W-1:0]    offset;
  logic [OFF_W-1:0]    a_off;
  logic                req;
  logic                wr_req;
  logic                ctrl_wr;
  logic [31:0]         rd_data;

  gat_pkg::weight_t    h_q    [`GAT_FEAT_IN];
  gat_pkg::wh_acc_t    wh_arr [`GAT_FEAT_OUT];
  gat_pkg::weight_t    a_arr  [`GAT_A_DEPTH];

  // ==========================================================================
  // Decode
  // ==========================================================================
  assign region  = gat_pkg::wb_region_e'(wb_adr[`GAT_WB_ADR_W-1 -: 2]);
  assign offset  = wb_adr[OFF_W-1:0];
  assign a_off   = offset - A_LO;

  // New request, the registered ack closes it one cycle later
  assign req     = wb_cyc && wb_stb && !wb_ack;
  assign wr_req  = req && wb_we;
  assign ctrl_wr = wr_req && (region == gat_pkg::WB_CTRL) && (offset == REG_CTRL);

  assign stage_we    = wr_req && (region == gat_pkg::WB_STAGE) && (offset < STAGE_END);
  assign stage_waddr = offset[STAGE_AW-1:0];
  assign stage_wdata = wb_dat_w[DW-1:0];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack     <= 1'b0;
      load_start <= 1'b0;
      wh_start   <= 1'b0;
    end else begin
      wb_ack     <= req;
      load_start <= ctrl_wr && wb_dat_w[0];
      wh_start   <= ctrl_wr && wb_dat_w[1];
    end
  end

  // Feature row h
  always_ff @(posedge clk) begin
    if (wr_req && (region == gat_pkg::WB_FEATURE) && (offset < FEAT_END)) begin
      h_q[offset[ROW_W-1:0]] <= wb_dat_w[DW-1:0];
    end
  end

  // ==========================================================================
  // Flat vectors to and from the datapath
  // ==========================================================================
  for (genvar r = 0; r < `GAT_FEAT_IN; r++) begin : g_h
    assign h_flat[r*DW +: DW] = h_q[r];
  end

  for (genvar c = 0; c < `GAT_FEAT_OUT; c++) begin : g_wh
    assign wh_arr[c] = wh_flat[c*WW +: WW];
  end

  for (genvar k = 0; k < `GAT_A_DEPTH; k++) begin : g_a
    assign a_arr[k] = a_flat[k*DW +: DW];
  end

  // Readback, results sign-extended to the bus width
  always_comb begin
    rd_data = '0;
    case (region)
      gat_pkg::WB_RESULT: begin
        if (offset < WH_END) begin
          rd_data = 32'(wh_arr[offset[COL_W-1:0]]);
        end else if (offset >= A_LO && offset < A_HI) begin
          rd_data = 32'(a_arr[a_off[A_IW-1:0]]);
        end
      end
      gat_pkg::WB_CTRL: begin
        if (offset == REG_STAT) begin
          rd_data = {29'd0, wh_done, a_ready, w_ready};
        end
      end
      default: begin
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (req) begin
      wb_dat_r <= rd_data;
    end
  end

  // The master must hold the strobe until the ack arrives
  a_ack_held: assert property (@(posedge clk) disable iff (!rst_n) wb_ack |-> wb_stb);

endmodule

// File: rtl/gat_weight_loader.sv
// Streams the staging memory into one weight bank per output column and
// captures the attention vector a. Owns the column banks read by the engine.
`timescale 1ns/10ps
`include "gat_config.svh"

module gat_weight_loader (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      load_start,
  output logic [$clog2(`GAT_STAGE_DEPTH)-1:0]       stage_raddr,
  input  gat_pkg::weight_t                          stage_rdata,
  input  logic [$clog2(`GAT_FEAT_IN)-1:0]           bank_raddr,
  output logic [`GAT_FEAT_OUT*`GAT_DATA_WIDTH-1:0]  bank_rdata_flat,
  output logic [`GAT_A_DEPTH*`GAT_DATA_WIDTH-1:0]   a_flat,
  output logic                                      w_ready,
  output logic                                      a_ready
);

  localparam int DW       = `GAT_DATA_WIDTH;
  localparam int STAGE_AW = $clog2(`GAT_STAGE_DEPTH);
  localparam int ROW_W    = $clog2(`GAT_FEAT_IN);
  localparam int COL_W    = $clog2(`GAT_FEAT_OUT);
  localparam int A_IW     = $clog2(`GAT_A_DEPTH);

  localparam logic [STAGE_AW-1:0] LAST_WORD = STAGE_AW'(`GAT_STAGE_DEPTH - 1);
  localparam logic [STAGE_AW-1:0] W_WORDS   = STAGE_AW'(`GAT_FEAT_IN * `GAT_FEAT_OUT);
  localparam logic [ROW_W-1:0]    LAST_ROW  = ROW_W'(`GAT_FEAT_IN - 1);
  localparam logic [COL_W-1:0]    LAST_COL  = COL_W'(`GAT_FEAT_OUT - 1);

  logic                      rd_busy;
  logic [STAGE_AW-1:0]       rd_addr;
  logic                      rd_vld;
  logic                      idle;

  // Position of the word returned by the staging memory
  logic [STAGE_AW-1:0]       wr_idx;
  logic [ROW_W-1:0]          wr_row;
  logic [COL_W-1:0]          wr_col;
  logic                      in_w;
  logic [STAGE_AW-1:0]       a_off;
  logic [`GAT_FEAT_OUT-1:0]  bank_we;

  gat_pkg::weight_t          a_q [`GAT_A_DEPTH];

  assign stage_raddr = rd_addr;
  assign idle        = !rd_busy && !rd_vld;
  assign in_w        = wr_idx < W_WORDS;
  assign a_off       = wr_idx - W_WORDS;

  // ==========================================================================
  // Read sequencing and write tracking
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_busy <= 1'b0;
      rd_addr <= '0;
      rd_vld  <= 1'b0;
      wr_idx  <= '0;
      wr_row  <= '0;
      wr_col  <= '0;
      w_ready <= 1'b0;
      a_ready <= 1'b0;
    end else begin
      // Staging data arrives one cycle after its address
      rd_vld <= rd_busy;
      if (load_start && idle) begin
        rd_busy <= 1'b1;
        rd_addr <= '0;
        wr_idx  <= '0;
        wr_row  <= '0;
        wr_col  <= '0;
        w_ready <= 1'b0;
        a_ready <= 1'b0;
      end else if (rd_busy) begin
        rd_addr <= rd_addr + 1'b1;
        if (rd_addr == LAST_WORD) begin
          rd_busy <= 1'b0;
        end
      end

      if (rd_vld) begin
        wr_idx <= wr_idx + 1'b1;
        if (in_w) begin
          // Row-major order wraps the column first
          if (wr_col == LAST_COL) begin
            wr_col <= '0;
            wr_row <= (wr_row == LAST_ROW) ? '0 : wr_row + 1'b1;
          end else begin
            wr_col <= wr_col + 1'b1;
          end
        end
        if (wr_idx == LAST_WORD) begin
          w_ready <= 1'b1;
          a_ready <= 1'b1;
        end
      end
    end
  end

  // Words after W go to the attention register file
  always_ff @(posedge clk) begin
    if (rd_vld && !in_w) begin
      a_q[a_off[A_IW-1:0]] <= stage_rdata;
    end
  end

  for (genvar k = 0; k < `GAT_A_DEPTH; k++) begin : g_a
    assign a_flat[k*DW +: DW] = a_q[k];
  end

  // ==========================================================================
  // Column banks
  // ==========================================================================
  // Only the bank of the current column is written
  for (genvar c = 0; c < `GAT_FEAT_OUT; c++) begin : g_bank
    assign bank_we[c] = rd_vld && in_w && (wr_col == COL_W'(c));

    gat_bram #(
      .DATA_WIDTH (DW),
      .DEPTH      (`GAT_FEAT_IN)
    ) i_bank (
      .clk   (clk),
      .rst_n (rst_n),
      .we    (bank_we[c]),
      .waddr (wr_row),
      .wdata (stage_rdata),
      .raddr (bank_raddr),
      .rdata (bank_rdata_flat[c*DW +: DW])
    );
  end

  // Banks take words only while a load is in progress
  a_no_idle_write: assert property (@(posedge clk) disable iff (!rst_n)
    (bank_we != '0) |-> !w_ready);

endmodule

// File: rtl/gat_wh_engine.sv
// Projection engine. Walks the rows of all weight banks in parallel and
// accumulates WH = h * W, one signed accumulator per output column.
`timescale 1ns/10ps
`include "gat_config.svh"

module gat_wh_engine (
  input  logic                                      clk,
  input  logic                                      rst_n,
  input  logic                                      wh_start,
  input  logic                                      w_ready,
  output logic [$clog2(`GAT_FEAT_IN)-1:0]           bank_raddr,
  input  logic [`GAT_FEAT_OUT*`GAT_DATA_WIDTH-1:0]  bank_rdata_flat,
  input  logic [`GAT_FEAT_IN*`GAT_DATA_WIDTH-1:0]   h_flat,
  output logic [`GAT_FEAT_OUT*`GAT_WH_WIDTH-1:0]    wh_flat,
  output logic                                      wh_done
);

  localparam int DW    = `GAT_DATA_WIDTH;
  localparam int WW    = `GAT_WH_WIDTH;
  localparam int ROW_W = $clog2(`GAT_FEAT_IN);

  localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`GAT_FEAT_IN - 1);

  logic                     busy;
  logic [ROW_W-1:0]         row;
  // Row index delayed by the bank read latency
  logic                     mac_vld;
  logic [ROW_W-1:0]         mac_row;
  logic                     mac_last;

  gat_pkg::weight_t         h_arr [`GAT_FEAT_IN];
  gat_pkg::weight_t         w_col [`GAT_FEAT_OUT];
  logic signed [2*DW-1:0]   prod  [`GAT_FEAT_OUT];
  gat_pkg::wh_acc_t         acc   [`GAT_FEAT_OUT];

  assign bank_raddr = row;

  for (genvar r = 0; r < `GAT_FEAT_IN; r++) begin : g_h
    assign h_arr[r] = h_flat[r*DW +: DW];
  end

  for (genvar c = 0; c < `GAT_FEAT_OUT; c++) begin : g_col
    assign w_col[c]            = bank_rdata_flat[c*DW +: DW];
    assign wh_flat[c*WW +: WW] = acc[c];
  end

  always_comb begin
    for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
      prod[c] = h_arr[mac_row] * w_col[c];
    end
  end

  // ==========================================================================
  // Row walk and accumulate
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      row      <= '0;
      mac_vld  <= 1'b0;
      mac_row  <= '0;
      mac_last <= 1'b0;
      wh_done  <= 1'b0;
      for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
        acc[c] <= '0;
      end
    end else begin
      mac_vld  <= busy;
      mac_row  <= row;
      mac_last <= busy && (row == LAST_ROW);
      if (wh_start && w_ready && !busy && !mac_vld) begin
        busy    <= 1'b1;
        row     <= '0;
        wh_done <= 1'b0;
        for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
          acc[c] <= '0;
        end
      end else begin
        if (busy) begin
          row <= row + 1'b1;
          if (row == LAST_ROW) begin
            busy <= 1'b0;
          end
        end
        if (mac_vld) begin
          for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
            acc[c] <= acc[c] + gat_pkg::wh_acc_t'(prod[c]);
          end
          if (mac_last) begin
            wh_done <= 1'b1;
          end
        end
      end
      // A reload invalidates the previous result
      if (!w_ready) begin
        wh_done <= 1'b0;
      end
    end
  end

endmodule

// File: rtl/gat_weight_top.sv
// Top level of the weight front end. Wishbone port, staging memory, weight
// loader and projection engine, connected by wires only.
`timescale 1ns/10ps
`include "gat_config.svh"

module gat_weight_top (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      wb_cyc,
  input  logic                      wb_stb,
  input  logic                      wb_we,
  input  logic [`GAT_WB_ADR_W-1:0]  wb_adr,
  input  logic [31:0]               wb_dat_w,
  output logic [31:0]               wb_dat_r,
  output logic                      wb_ack
);

  localparam int STAGE_AW = $clog2(`GAT_STAGE_DEPTH);

  logic                                      stage_we;
  logic [STAGE_AW-1:0]                       stage_waddr;
  gat_pkg::weight_t                          stage_wdata;
  logic [STAGE_AW-1:0]                       stage_raddr;
  gat_pkg::weight_t                          stage_rdata;
  logic                                      load_start;
  logic                                      wh_start;
  logic                                      w_ready;
  logic                                      a_ready;
  logic                                      wh_done;
  logic [$clog2(`GAT_FEAT_IN)-1:0]           bank_raddr;
  logic [`GAT_FEAT_OUT*`GAT_DATA_WIDTH-1:0]  bank_rdata_flat;
  logic [`GAT_FEAT_IN*`GAT_DATA_WIDTH-1:0]   h_flat;
  logic [`GAT_FEAT_OUT*`GAT_WH_WIDTH-1:0]    wh_flat;
  logic [`GAT_A_DEPTH*`GAT_DATA_WIDTH-1:0]   a_flat;

  gat_wb_port i_wb_port (
    .clk             (clk),
    .rst_n           (rst_n),
    .wb_cyc          (wb_cyc),
    .wb_stb          (wb_stb),
    .wb_we           (wb_we),
    .wb_adr          (wb_adr),
    .wb_dat_w        (wb_dat_w),
    .wb_dat_r        (wb_dat_r),
    .wb_ack          (wb_ack),
    .stage_we        (stage_we),
    .stage_waddr     (stage_waddr),
    .stage_wdata     (stage_wdata),
    .load_start      (load_start),
    .wh_start        (wh_start),
    .h_flat          (h_flat),
    .w_ready         (w_ready),
    .a_ready         (a_ready),
    .wh_done         (wh_done),
    .wh_flat         (wh_flat),
    .a_flat          (a_flat)
  );

  // Staging memory, W row-major followed by a
  gat_bram #(
    .DATA_WIDTH (`GAT_DATA_WIDTH),
    .DEPTH      (`GAT_STAGE_DEPTH)
  ) i_stage_bram (
    .clk   (clk),
    .rst_n (rst_n),
    .we    (stage_we),
    .waddr (stage_waddr),
    .wdata (stage_wdata),
    .raddr (stage_raddr),
    .rdata (stage_rdata)
  );

  gat_weight_loader i_loader (
    .clk             (clk),
    .rst_n           (rst_n),
    .load_start      (load_start),
    .stage_raddr     (stage_raddr),
    .stage_rdata     (stage_rdata),
    .bank_raddr      (bank_raddr),
    .bank_rdata_flat (bank_rdata_flat),
    .a_flat          (a_flat),
    .w_ready         (w_ready),
    .a_ready         (a_ready)
  );

  gat_wh_engine i_engine (
    .clk             (clk),
    .rst_n           (rst_n),
    .wh_start        (wh_start),
    .w_ready         (w_ready),
    .bank_raddr      (bank_raddr),
    .bank_rdata_flat (bank_rdata_flat),
    .h_flat          (h_flat),
    .wh_flat         (wh_flat),
    .wh_done         (wh_done)
  );

endmodule

// File: bench/gat_checker.sv
// Bus monitor of the weight front end testbench. Builds a reference model
// of W, a, h and STATUS from the acknowledged writes and checks every read.
`timescale 1ns/10ps
`include "gat_config.svh"

module gat_checker (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`GAT_WB_ADR_W-1:0] wb_adr,
  input  logic [31:0]              wb_dat_w,
  input  logic [31:0]              wb_dat_r,
  input  logic                     wb_ack,
  output int                       errors,
  output int                       reads
);

  localparam int OFF_W   = `GAT_WB_ADR_W - 2;
  localparam int W_WORDS = `GAT_FEAT_IN * `GAT_FEAT_OUT;

  int         stage_m [`GAT_STAGE_DEPTH];
  int         w_m     [`GAT_FEAT_IN][`GAT_FEAT_OUT];
  int         a_m     [`GAT_A_DEPTH];
  int         h_m     [`GAT_FEAT_IN];
  int         wh_m    [`GAT_FEAT_OUT];
  bit         a_known;
  // STATUS as last seen, and the value it moves to once a run ends
  logic [2:0] stat_now;
  logic [2:0] stat_next;
  bit         stat_pending;

  // Low byte of a bus word as a signed element
  function automatic int to_element(input logic [31:0] word);
    logic signed [`GAT_DATA_WIDTH-1:0] e;
    e = word[`GAT_DATA_WIDTH-1:0];
    return int'(e);
  endfunction

  task automatic reset_model();
    for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
      wh_m[c] = 0;
    end
    a_known      = 1'b0;
    stat_now     = 3'b000;
    stat_next    = 3'b000;
    stat_pending = 1'b0;
  endtask

  // Load copies the staged words, W row-major and then a
  task automatic start_load();
    for (int i = 0; i < W_WORDS; i++) begin
      w_m[i / `GAT_FEAT_OUT][i % `GAT_FEAT_OUT] = stage_m[i];
    end
    for (int k = 0; k < `GAT_A_DEPTH; k++) begin
      a_m[k] = stage_m[W_WORDS + k];
    end
    a_known      = 1'b1;
    stat_now     = 3'b000;
    stat_next    = 3'b011;
    stat_pending = 1'b1;
  endtask

  // A projection only starts once the weights are ready
  task automatic start_projection();
    int sum;
    if (stat_now[0]) begin
      for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
        sum = 0;
        for (int r = 0; r < `GAT_FEAT_IN; r++) begin
          sum += h_m[r] * w_m[r][c];
        end
        wh_m[c] = sum;
      end
      stat_now     = 3'b011;
      stat_next    = 3'b111;
      stat_pending = 1'b1;
    end
  endtask

  task automatic apply_write(input gat_pkg::wb_region_e region, input int off,
                             input logic [31:0] data);
    case (region)
      gat_pkg::WB_STAGE: begin
        if (off < `GAT_STAGE_DEPTH) begin
          stage_m[off] = to_element(data);
        end
      end
      gat_pkg::WB_FEATURE: begin
        if (off < `GAT_FEAT_IN) begin
          h_m[off] = to_element(data);
        end
      end
      gat_pkg::WB_CTRL: begin
        if (off == `GAT_REG_CTRL && data[0]) begin
          start_load();
        end else if (off == `GAT_REG_CTRL && data[1]) begin
          start_projection();
        end
      end
      default: begin
      end
    endcase
  endtask

  task automatic check_read(input gat_pkg::wb_region_e region, input int off,
                            input logic [31:0] data);
    logic [31:0] exp;
    bit          known;
    exp   = '0;
    known = 1'b1;
    case (region)
      gat_pkg::WB_RESULT: begin
        if (off < `GAT_FEAT_OUT) begin
          exp = 32'(wh_m[off]);
        end else if (off >= `GAT_A_BASE && off < `GAT_A_BASE + `GAT_A_DEPTH) begin
          exp   = 32'(a_m[off - `GAT_A_BASE]);
          known = a_known;
        end
      end
      gat_pkg::WB_CTRL: begin
        if (off == `GAT_REG_STATUS) begin
          if (stat_pending && data == {29'd0, stat_next}) begin
            stat_now     = stat_next;
            stat_pending = 1'b0;
          end
          exp = {29'd0, stat_now};
        end
      end
      default: begin
      end
    endcase
    reads++;
    if (known && data !== exp) begin
      errors++;
      $display("Mismatch at %0t: read of word 0x%0h returned 0x%08h, expected 0x%08h",
               $time, {region, OFF_W'(off)}, data, exp);
    end
  endtask

  initial begin
    errors = 0;
    reads  = 0;
    for (int i = 0; i < `GAT_STAGE_DEPTH; i++) begin
      stage_m[i] = 0;
    end
    for (int r = 0; r < `GAT_FEAT_IN; r++) begin
      h_m[r] = 0;
    end
    reset_model();
  end

  // Pre-edge values, so the ack seen here closes exactly one transfer
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reset_model();
    end else if (wb_cyc && wb_stb && wb_ack) begin
      if (wb_we) begin
        apply_write(gat_pkg::wb_region_e'(wb_adr[`GAT_WB_ADR_W-1 -: 2]),
                    int'(wb_adr[OFF_W-1:0]), wb_dat_w);
      end else begin
        check_read(gat_pkg::wb_region_e'(wb_adr[`GAT_WB_ADR_W-1 -: 2]),
                   int'(wb_adr[OFF_W-1:0]), wb_dat_r);
      end
    end
  end

endmodule

// File: bench/tb_gat_weight.sv
// Testbench of the weight front end. Acts as Wishbone master through the
// load and projection tests while the checker module compares every read.
`timescale 1ns/10ps
`include "gat_config.svh"

module tb_gat_weight;

  localparam int CLK_PERIOD   = 8;
  localparam int ADR_W        = `GAT_WB_ADR_W;
  localparam int OFF_W        = `GAT_WB_ADR_W - 2;
  localparam int NUM_ROUNDS   = 4;
  localparam int ACK_LIMIT    = 8;
  localparam int POLL_LIMIT   = 2 * `GAT_STAGE_DEPTH;
  // Staging writes, status polls, h writes and readback of one round
  localparam int ROUND_CYCLES = 10 * `GAT_STAGE_DEPTH + 200;
  localparam int WATCHDOG_NS  = (NUM_ROUNDS + 6) * ROUND_CYCLES * CLK_PERIOD;

  logic             clk;
  logic             rst_n;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [ADR_W-1:0] wb_adr;
  logic [31:0]      wb_dat_w;
  logic [31:0]      wb_dat_r;
  logic             wb_ack;

  int               chk_errors;
  int               chk_reads;
  int               tb_errors;
  int               errors_at_start;
  int               tests_run;
  int               tests_failed;
  logic [31:0]      rd_word;

  always #(CLK_PERIOD / 2) clk = ~clk;

  gat_weight_top i_gat_weight_top (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  gat_checker i_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .errors   (chk_errors),
    .reads    (chk_reads)
  );

  function automatic logic [ADR_W-1:0] word_addr(input gat_pkg::wb_region_e region,
                                                 input int offset);
    return {region, OFF_W'(offset)};
  endfunction

  // ==========================================================================
  // Wishbone master
  // ==========================================================================
  task automatic bus_cycle(input logic we, input logic [ADR_W-1:0] adr,
                           input logic [31:0] wdata, output logic [31:0] rdata);
    int waits;
    @(posedge clk);
    wb_cyc   <= 1'b1;
    wb_stb   <= 1'b1;
    wb_we    <= we;
    wb_adr   <= adr;
    wb_dat_w <= wdata;
    waits = 0;
    @(negedge clk);
    while (!wb_ack && waits < ACK_LIMIT) begin
      waits++;
      @(negedge clk);
    end
    if (!wb_ack) begin
      $display("Error at %0t: no ack for address 0x%0h", $time, adr);
      tb_errors++;
    end else if (waits != 1) begin
      $display("Error at %0t: ack for address 0x%0h came after %0d cycles, expected 1",
               $time, adr, waits);
      tb_errors++;
    end
    rdata = wb_dat_r;
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic write_word(input logic [ADR_W-1:0] adr, input logic [31:0] data);
    logic [31:0] unused;
    bus_cycle(1'b1, adr, data, unused);
  endtask

  task automatic read_word(input logic [ADR_W-1:0] adr, output logic [31:0] data);
    bus_cycle(1'b0, adr, 32'd0, data);
  endtask

  task automatic wait_status(input logic [2:0] mask, input string what);
    logic [31:0] st;
    int          polls;
    st    = '0;
    polls = 0;
    while ((st[2:0] & mask) != mask && polls < POLL_LIMIT) begin
      read_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_STATUS), st);
      polls++;
    end
    if ((st[2:0] & mask) != mask) begin
      $display("Error at %0t: STATUS never showed %s within %0d polls",
               $time, what, POLL_LIMIT);
      tb_errors++;
    end
  endtask

  // ==========================================================================
  // Stimulus
  // ==========================================================================
  task automatic stage_random();
    for (int i = 0; i < `GAT_STAGE_DEPTH; i++) begin
      write_word(word_addr(gat_pkg::WB_STAGE, i), $urandom);
    end
  endtask

  task automatic stage_fill(input int w_val, input int a_val);
    for (int i = 0; i < `GAT_STAGE_DEPTH; i++) begin
      write_word(word_addr(gat_pkg::WB_STAGE, i),
                 32'((i < `GAT_FEAT_IN * `GAT_FEAT_OUT) ? w_val : a_val));
    end
  endtask

  task automatic feature_random();
    for (int r = 0; r < `GAT_FEAT_IN; r++) begin
      write_word(word_addr(gat_pkg::WB_FEATURE, r), $urandom);
    end
  endtask

  task automatic feature_fill(input int val);
    for (int r = 0; r < `GAT_FEAT_IN; r++) begin
      write_word(word_addr(gat_pkg::WB_FEATURE, r), 32'(val));
    end
  endtask

  task automatic load_weights();
    write_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_CTRL), 32'h1);
    wait_status(3'b011, "w_ready and a_ready");
  endtask

  task automatic project();
    write_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_CTRL), 32'h2);
    wait_status(3'b100, "wh_done");
  endtask

  task automatic read_results();
    logic [31:0] data;
    for (int c = 0; c < `GAT_FEAT_OUT; c++) begin
      read_word(word_addr(gat_pkg::WB_RESULT, c), data);
    end
    for (int k = 0; k < `GAT_A_DEPTH; k++) begin
      read_word(word_addr(gat_pkg::WB_RESULT, `GAT_A_BASE + k), data);
    end
  endtask

  // Let the checker finish the last compare before counting
  task automatic end_test(input int num, input string name);
    int errs;
    @(negedge clk);
    errs = chk_errors + tb_errors;
    tests_run++;
    if (errs != errors_at_start) begin
      tests_failed++;
      $display("Test %0d %s: FAIL, %0d errors", num, name, errs - errors_at_start);
    end else begin
      $display("Test %0d %s: ok", num, name);
    end
    errors_at_start = errs;
  endtask

  // ==========================================================================
  // Test sequence
  // ==========================================================================
  initial begin
    void'($urandom(32'h8692));
    clk             = 1'b0;
    rst_n           = 1'b0;
    wb_cyc          = 1'b0;
    wb_stb          = 1'b0;
    wb_we           = 1'b0;
    wb_adr          = '0;
    wb_dat_w        = '0;
    tb_errors       = 0;
    errors_at_start = 0;
    tests_run       = 0;
    tests_failed    = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;

    // Start before any load must be ignored
    read_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_STATUS), rd_word);
    write_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_CTRL), 32'h2);
    repeat (`GAT_FEAT_IN + 4) @(posedge clk);
    read_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_STATUS), rd_word);
    end_test(1, "status after reset, start before load");

    stage_random();
    load_weights();
    read_results();
    end_test(2, "random load");

    feature_random();
    project();
    read_results();
    end_test(3, "random projection");

    stage_random();
    write_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_CTRL), 32'h1);
    read_word(word_addr(gat_pkg::WB_CTRL, `GAT_REG_STATUS), rd_word);
    if (rd_word != 32'd0) begin
      $display("Mismatch at %0t: STATUS 0x%0h right after load start, expected 0",
               $time, rd_word);
      tb_errors++;
    end
    wait_status(3'b011, "w_ready and a_ready");
    feature_random();
    project();
    read_results();
    end_test(4, "reload");

    stage_fill(-128, 127);
    feature_fill(-128);
    load_weights();
    project();
    read_results();
    feature_fill(127);
    project();
    read_results();
    end_test(5, "extreme values");

    for (int n = 0; n < NUM_ROUNDS; n++) begin
      stage_random();
      load_weights();
      feature_random();
      project();
      read_results();
    end
    end_test(6, "random rounds");

    $display("Tests run %0d, failed %0d, reads checked %0d, errors %0d",
             tests_run, tests_failed, chk_reads, chk_errors + tb_errors);
    if (chk_errors + tb_errors == 0 && tests_failed == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, the test sequence did not finish",
             WATCHDOG_NS);
    $display("Regression failed");
    $finish;
  end

endmodule

// File: gat_weight.f
+incdir+rtl
rtl/gat_pkg.sv
rtl/gat_bram.sv
rtl/gat_wb_port.sv
rtl/gat_weight_loader.sv
rtl/gat_wh_engine.sv
rtl/gat_weight_top.sv
bench/gat_checker.sv
bench/tb_gat_weight.sv

// File: Makefile
# Verilator flow for the weight front end.
# Override any variable on the command line, for example make sim OBJ_DIR=build

VERILATOR  ?= verilator
TOP        ?= tb_gat_weight
LINT_TOP   ?= gat_weight_top
FILELIST   ?= gat_weight.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing -Wno-fatal -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= Regression passed

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The run passes only if the pass message shows up in the output
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
